// File: cpu_pkg.sv
package cpu_pkg;

    ////////////////////
    // Widths and types

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t PC_STEP  = 32'd4;

    ////////////////////
    // Encodings

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 and funct7 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    ////////////////////
    // Operations and state

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_JAL} branch_op_t;

    typedef enum logic [1:0] {ST_FETCH, ST_DECODE, ST_EXECUTE, ST_LOAD_WAIT} core_state_t;

    typedef struct packed {
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      imm;
        logic       use_imm;
        alu_op_t    alu_op;
        branch_op_t branch_op;
        logic       is_load;
        logic       is_store;
        logic       reg_write;
    } decode_t;

    // Memory ports, no handshake
    typedef struct packed {
        logic  en;
        word_t addr;
    } imem_req_t;

    typedef struct packed {
        logic  en;
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

endpackage

// File: fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      fetch_en,
    input  logic      pc_update,
    input  word_t     next_pc,
    output word_t     pc,
    output imem_req_t imem_req
);

    word_t pc_q;

    // Program counter, moves once per instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (pc_update) begin
            pc_q <= next_pc;
        end
    end

    assign pc = pc_q;

    // Request strobe comes straight from the sequencer
    always_comb begin
        imem_req.en   = fetch_en;
        imem_req.addr = pc_q;
    end

endmodule

// File: decode_unit.sv
`timescale 1ns/100ps

module decode_unit
    import cpu_pkg::*;
(
    input  word_t   instr,
    output decode_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    ////////////////////
    // Immediates, all sign-extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////
    // Control fields
    always_comb begin
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.rd        = instr[11:7];
        dec.imm       = '0;
        dec.use_imm   = 1'b0;
        dec.alu_op    = ALU_ADD;
        dec.branch_op = BR_NONE;
        dec.is_load   = 1'b0;
        dec.is_store  = 1'b0;
        dec.reg_write = 1'b0;

        // Anything not matched below falls through as a no-op
        case (opcode)
            OPC_OP: begin
                dec.reg_write = 1'b1;
                if (funct3 == F3_ADD_SUB && funct7 == F7_BASE) dec.alu_op = ALU_ADD;
                else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) dec.alu_op = ALU_SUB;
                else if (funct3 == F3_AND && funct7 == F7_BASE) dec.alu_op = ALU_AND;
                else if (funct3 == F3_OR && funct7 == F7_BASE) dec.alu_op = ALU_OR;
                else if (funct3 == F3_XOR && funct7 == F7_BASE) dec.alu_op = ALU_XOR;
                else if (funct3 == F3_SLT && funct7 == F7_BASE) dec.alu_op = ALU_SLT;
                else dec.reg_write = 1'b0;
            end
            OPC_OP_IMM: begin
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.reg_write = (funct3 == F3_ADD_SUB);
            end
            OPC_LUI: begin
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.alu_op    = ALU_PASS_B;
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.is_load   = (funct3 == F3_WORD);
                dec.reg_write = (funct3 == F3_WORD);
            end
            OPC_STORE: begin
                dec.imm      = imm_s;
                dec.use_imm  = 1'b1;
                dec.is_store = (funct3 == F3_WORD);
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                if (funct3 == F3_BEQ) dec.branch_op = BR_EQ;
                else if (funct3 == F3_BNE) dec.branch_op = BR_NE;
            end
            OPC_JAL: begin
                dec.imm       = imm_j;
                dec.branch_op = BR_JAL;
                dec.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: register_file.sv
`timescale 1ns/100ps

module register_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     wdata
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 always reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: alu_unit.sv
`timescale 1ns/100ps

module alu_unit
    import cpu_pkg::*;
(
    input  decode_t dec,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    output word_t   result
);

    word_t op_b;
    logic  lt;

    // Immediate forms and memory addressing take the immediate
    assign op_b = dec.use_imm ? dec.imm : rs2_data;
    assign lt   = $signed(rs1_data) < $signed(op_b);

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    result = rs1_data + op_b;
            ALU_SUB:    result = rs1_data - op_b;
            ALU_AND:    result = rs1_data & op_b;
            ALU_OR:     result = rs1_data | op_b;
            ALU_XOR:    result = rs1_data ^ op_b;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt};
            ALU_PASS_B: result = op_b;
            default:    result = rs1_data + op_b;
        endcase
    end

endmodule

// File: branch_unit.sv
`timescale 1ns/100ps

module branch_unit
    import cpu_pkg::*;
(
    input  decode_t dec,
    input  word_t   pc,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    output word_t   next_pc,
    output word_t   link
);

    logic equal;
    logic taken;

    assign equal = (rs1_data == rs2_data);

    // JAL is always taken
    assign taken = (dec.branch_op == BR_EQ && equal) ||
                   (dec.branch_op == BR_NE && !equal) ||
                   (dec.branch_op == BR_JAL);

    assign link    = pc + PC_STEP;
    assign next_pc = taken ? pc + dec.imm : link;

endmodule

// File: load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      exec_en,
    input  decode_t   dec,
    input  word_t     addr,
    input  word_t     store_data,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    output word_t     load_data
);

    logic load_pending;

    ////////////////////
    // Request, only in the execute cycle
    always_comb begin
        dmem_req.en    = exec_en && (dec.is_load || dec.is_store);
        dmem_req.we    = exec_en && dec.is_store;
        dmem_req.addr  = addr;
        dmem_req.wdata = store_data;
    end

    ////////////////////
    // Return path
    // Memory answers one cycle after the read strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_pending <= 1'b0;
        end else begin
            load_pending <= exec_en && dec.is_load;
        end
    end

    assign load_data = load_pending ? dmem_rdata : '0;

endmodule

// File: core_control.sv
`timescale 1ns/100ps

module core_control
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  word_t   instr_rdata,
    input  decode_t dec,
    output word_t   instr,
    output logic    fetch_en,
    output logic    pc_update,
    output logic    exec_en,
    output logic    reg_we,
    output logic    wb_from_load,
    output core_state_t state
);

    core_state_t next_state;

    ////////////////////
    // Sequencer FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            ST_FETCH:     next_state = ST_DECODE;
            ST_DECODE:    next_state = ST_EXECUTE;
            ST_EXECUTE:   next_state = dec.is_load ? ST_LOAD_WAIT : ST_FETCH;
            ST_LOAD_WAIT: next_state = ST_FETCH;
            default:      next_state = ST_FETCH;
        endcase
    end

    // Instruction word arrives in the decode cycle
    always_ff @(posedge clk) begin
        if (state == ST_DECODE) begin
            instr <= instr_rdata;
        end
    end

    ////////////////////
    // Strobes
    assign fetch_en     = (state == ST_FETCH);
    assign pc_update    = (state == ST_EXECUTE);
    assign exec_en      = (state == ST_EXECUTE);
    assign wb_from_load = (state == ST_LOAD_WAIT);
    assign reg_we       = dec.reg_write &&
                          ((state == ST_EXECUTE && !dec.is_load) || state == ST_LOAD_WAIT);

endmodule

// File: cpu_core.sv
`timescale 1ns/100ps

module cpu_core
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    output imem_req_t imem_req,
    input  word_t     instr_rdata,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata
);

    word_t       pc;
    word_t       next_pc;
    word_t       link;
    word_t       instr;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       alu_result;
    word_t       load_data;
    word_t       wb_data;
    decode_t     dec;
    logic        fetch_en;
    logic        pc_update;
    logic        exec_en;
    logic        reg_we;
    logic        wb_from_load;

    ////////////////////
    // Fetch and control
    fetch_unit u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_en  (fetch_en),
        .pc_update (pc_update),
        .next_pc   (next_pc),
        .pc        (pc),
        .imem_req  (imem_req)
    );

    core_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_rdata  (instr_rdata),
        .dec          (dec),
        .instr        (instr),
        .fetch_en     (fetch_en),
        .pc_update    (pc_update),
        .exec_en      (exec_en),
        .reg_we       (reg_we),
        .wb_from_load (wb_from_load),
        .state        ()
    );

    decode_unit u_decode (
        .instr (instr),
        .dec   (dec)
    );

    ////////////////////
    // Registers and execution
    register_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (reg_we),
        .rd       (dec.rd),
        .wdata    (wb_data)
    );

    alu_unit u_alu (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result)
    );

    branch_unit u_branch (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .next_pc  (next_pc),
        .link     (link)
    );

    load_store_unit u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_en    (exec_en),
        .dec        (dec),
        .addr       (alu_result),
        .store_data (rs2_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data)
    );

    // Writeback source
    assign wb_data = wb_from_load ? load_data :
                     (dec.branch_op == BR_JAL) ? link : alu_result;

endmodule

// File: cpu_core_properties.sv
`timescale 1ns/100ps

module cpu_core_properties
    import cpu_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input imem_req_t   imem_req,
    input dmem_req_t   dmem_req
);

    int fail_count = 0;

    // One memory port active per cycle
    one_port: assert property (@(posedge clk) disable iff (!rst_n)
        !(imem_req.en && dmem_req.en))
    else begin
        $error("instruction and data requests in the same cycle");
        fail_count++;
    end

    fetch_gap: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req.en |=> !imem_req.en ##1 !imem_req.en)
    else begin
        $error("instruction fetches closer than three cycles");
        fail_count++;
    end

    we_with_en: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.we |-> dmem_req.en)
    else begin
        $error("data write strobe without a request");
        fail_count++;
    end

    // First cycle out of reset fetches from the reset vector
    first_fetch: assert property (@(posedge clk)
        $rose(rst_n) |-> imem_req.en && imem_req.addr == RESET_PC)
    else begin
        $error("first fetch after reset is not at the reset vector");
        fail_count++;
    end

endmodule

bind cpu_core cpu_core_properties u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .imem_req (imem_req),
    .dmem_req (dmem_req)
);

// File: tb_cpu_core.sv
`timescale 1ns/100ps

module tb_cpu_core
    import cpu_pkg::*;
();

    localparam int    CLK_PERIOD = 4;
    localparam int    MEM_WORDS  = 256;
    localparam word_t LFSR_TAPS  = 32'hA300_0000;
    // Worst case 4 cycles per executed instruction, plus reset per run
    localparam int    RUN_CYCLES = 4 * (3 + 2 * 17 + 7 + 11) + 5 * 5;
    localparam int    MARGIN     = 100;

    logic      clk;
    logic      rst_n;
    imem_req_t imem_req;
    word_t     instr_rdata;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];
    word_t lfsr;

    logic  fetch_pend;
    logic  load_pend;
    word_t fetch_addr;
    word_t load_addr;
    word_t fetched;
    word_t halt_pc;
    logic  have_fetch;
    logic  last_was_lw;
    logic  halted;
    int    cyc_count;
    int    last_fetch_cyc;
    int    first_fetch_cyc;
    int    dmem_reads;

    word_t prog [$];
    word_t fetch_q [$];
    word_t store_addr_q [$];
    word_t store_data_q [$];
    word_t exp_addr_q [$];
    word_t exp_data_q [$];

    cpu_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req    (imem_req),
        .instr_rdata (instr_rdata),
        .dmem_req    (dmem_req),
        .dmem_rdata  (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (RUN_CYCLES + MARGIN));
        fail_run("Timeout: the core never reached the end of its program");
    end

    ////////////////////
    // Memory models
    // Requests are taken at the rising edge, answers driven at the falling edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (imem_req.en) begin
                if (have_fetch) begin
                    check_word(word_t'(cyc_count - last_fetch_cyc),
                               last_was_lw ? 32'd4 : 32'd3, "fetch spacing");
                end else begin
                    first_fetch_cyc = cyc_count;
                end
                have_fetch     = 1'b1;
                last_fetch_cyc = cyc_count;
                fetched        = imem[imem_req.addr[9:2]];
                last_was_lw    = fetched[6:0] == OPC_LOAD && fetched[14:12] == F3_WORD;
                fetch_q.push_back(imem_req.addr);
                halted = halted || imem_req.addr == halt_pc;
            end
            if (dmem_req.en && dmem_req.we) begin
                check_word(word_t'(cyc_count - last_fetch_cyc), 32'd2, "store after its fetch");
                store_addr_q.push_back(dmem_req.addr);
                store_data_q.push_back(dmem_req.wdata);
                dmem[dmem_req.addr[9:2]] = dmem_req.wdata;
            end else if (dmem_req.en) begin
                dmem_reads++;
            end
            cyc_count++;
        end
        fetch_pend = imem_req.en;
        fetch_addr = imem_req.addr;
        load_pend  = dmem_req.en && !dmem_req.we;
        load_addr  = dmem_req.addr;
    end

    always @(negedge clk) begin
        instr_rdata = fetch_pend ? imem[fetch_addr[9:2]] : '0;
        dmem_rdata  = load_pend ? dmem[load_addr[9:2]] : '0;
    end

    ////////////////////
    // Instruction encoders
    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [6:0] opc, input reg_addr_t rd,
                                     input logic [2:0] f3, input reg_addr_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input reg_addr_t rs2, input reg_addr_t rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(input reg_addr_t rd, input logic [19:0] up);
        return {up, rd, OPC_LUI};
    endfunction

    function automatic word_t j_type(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Galois LFSR, one step per bit drawn
    function automatic word_t rand_bits(input int n);
        word_t v;
        int    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[XLEN-2:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ LFSR_TAPS : lfsr >> 1;
        end
        return v;
    endfunction

    ////////////////////
    // Checks
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input word_t got, input word_t exp, input string role);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s address is %h, expected %h",
                               $time, role, got, exp));
        end
    endtask

    ////////////////////
    // Program handling
    task automatic clear_program();
        prog.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    // LUI then ADDI, the immediate of ADDI is sign-extended
    task automatic push_const(input reg_addr_t rd, output word_t value);
        logic [19:0] up;
        logic [11:0] lo;
        word_t       r;
        r  = rand_bits(20);
        up = r[19:0];
        r  = rand_bits(12);
        lo = r[11:0];
        prog.push_back(u_type(rd, up));
        prog.push_back(i_type(OPC_OP_IMM, rd, F3_ADD_SUB, rd, lo));
        value = {up, 12'b0} + {{20{lo[11]}}, lo};
    endtask

    // Last word of prog is the halt loop
    task automatic run_program();
        int i;
        @(negedge clk);
        rst_n = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : ((word_t'(i) << 7) | 32'h7F);
            dmem[i] = (word_t'(i) << 2) ^ 32'hC0DE_0000;
        end
        halt_pc = word_t'(prog.size() - 1) << 2;
        fetch_q.delete();
        store_addr_q.delete();
        store_data_q.delete();
        have_fetch  = 1'b0;
        last_was_lw = 1'b0;
        halted      = 1'b0;
        cyc_count   = 0;
        dmem_reads  = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        while (!halted) @(negedge clk);
        check_word(word_t'(store_addr_q.size()), word_t'(exp_addr_q.size()), "store count");
        foreach (exp_addr_q[k]) begin
            check_addr(store_addr_q[k], exp_addr_q[k], $sformatf("store %0d", k));
            check_word(store_data_q[k], exp_data_q[k], $sformatf("store %0d data", k));
        end
    endtask

    ////////////////////
    // Directed tests
    task automatic reset_and_x0_test();
        word_t imm;
        clear_program();
        imm = rand_bits(11) | 32'd1;
        prog.push_back(i_type(OPC_OP_IMM, 5'd0, F3_ADD_SUB, 5'd0, imm[11:0]));
        prog.push_back(s_type(5'd0, 5'd0, 12'h1C0));
        prog.push_back(j_type(5'd0, 21'd0));
        exp_addr_q.push_back(32'h1C0);
        exp_data_q.push_back(32'h0);
        run_program();
        check_addr(fetch_q[0], RESET_PC, "first fetch");
        check_word(word_t'(first_fetch_cyc), 32'd0, "first fetch cycle");
        check_word(word_t'(dmem_reads), 32'd0, "data read count");
    endtask

    task automatic alu_ops_test();
        logic [2:0] f3 [6];
        logic [6:0] f7 [6];
        word_t      a;
        word_t      b;
        word_t      addr;
        int         i;
        f3 = '{F3_ADD_SUB, F3_ADD_SUB, F3_AND, F3_OR, F3_XOR, F3_SLT};
        f7 = '{F7_BASE, F7_SUB, F7_BASE, F7_BASE, F7_BASE, F7_BASE};
        clear_program();
        push_const(5'd1, a);
        push_const(5'd2, b);
        for (i = 0; i < 6; i++) begin
            prog.push_back(r_type(f7[i], 5'd2, 5'd1, f3[i], reg_addr_t'(3 + i)));
        end
        for (i = 0; i < 6; i++) begin
            addr = 32'h100 + 4 * i;
            prog.push_back(s_type(reg_addr_t'(3 + i), 5'd0, addr[11:0]));
            exp_addr_q.push_back(addr);
        end
        prog.push_back(j_type(5'd0, 21'd0));
        exp_data_q = {a + b, a - b, a & b, a | b, a ^ b, word_t'($signed(a) < $signed(b))};
        run_program();
    endtask

    task automatic round_trip_test();
        word_t v;
        clear_program();
        push_const(5'd1, v);
        prog.push_back(s_type(5'd1, 5'd0, 12'h180));
        prog.push_back(i_type(OPC_LOAD, 5'd2, F3_WORD, 5'd0, 12'h180));
        prog.push_back(i_type(OPC_OP_IMM, 5'd2, F3_ADD_SUB, 5'd2, 12'd1));
        prog.push_back(s_type(5'd2, 5'd0, 12'h184));
        prog.push_back(j_type(5'd0, 21'd0));
        exp_addr_q = {32'h180, 32'h184};
        exp_data_q = {v, v + 32'd1};
        run_program();
    endtask

    task automatic control_flow_test();
        word_t a;
        word_t exp_pc [$];
        clear_program();
        a = rand_bits(12);
        // x3 holds the marker that only wrong-path stores would write
        prog = {i_type(OPC_OP_IMM, 5'd3, F3_ADD_SUB, 5'd0, 12'h5A5),
                i_type(OPC_OP_IMM, 5'd1, F3_ADD_SUB, 5'd0, a[11:0]),
                i_type(OPC_OP_IMM, 5'd2, F3_ADD_SUB, 5'd0, a[11:0]),
                b_type(F3_BEQ, 5'd1, 5'd2, 13'd8),
                s_type(5'd3, 5'd0, 12'h200),
                b_type(F3_BNE, 5'd1, 5'd2, 13'd8),
                i_type(OPC_OP_IMM, 5'd2, F3_ADD_SUB, 5'd2, 12'd1),
                b_type(F3_BNE, 5'd1, 5'd2, 13'd8),
                s_type(5'd3, 5'd0, 12'h204),
                b_type(F3_BEQ, 5'd1, 5'd2, 13'd8),
                j_type(5'd5, 21'd8),
                s_type(5'd3, 5'd0, 12'h208),
                s_type(5'd5, 5'd0, 12'h20C),
                j_type(5'd0, 21'd0)};
        // Taken branch at 12, 28 and JAL at 40 each skip one word
        exp_pc = {32'd0, 32'd4, 32'd8, 32'd12, 32'd20, 32'd24, 32'd28,
                  32'd36, 32'd40, 32'd48, 32'd52};
        exp_addr_q.push_back(32'h20C);
        exp_data_q.push_back(32'd40 + PC_STEP);
        run_program();
        check_word(word_t'(fetch_q.size()), word_t'(exp_pc.size()), "fetch count");
        foreach (exp_pc[k]) begin
            check_addr(fetch_q[k], exp_pc[k], $sformatf("fetch %0d", k));
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_rdata = '0;
        dmem_rdata  = '0;
        fetch_pend  = 1'b0;
        load_pend   = 1'b0;
        fetch_addr  = '0;
        load_addr   = '0;
        halt_pc     = '1;
        halted      = 1'b0;
        have_fetch  = 1'b0;
        cyc_count   = 0;
        lfsr        = 32'h59a9_5e39;
        reset_and_x0_test();
        repeat (2) alu_ops_test();
        round_trip_test();
        control_flow_test();
        @(negedge clk);
        if (dut.u_props.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run("Bound assertions on the core reported failures");
        end
    end

endmodule

// File: sources.f
cpu_pkg.sv
fetch_unit.sv
decode_unit.sv
register_file.sv
alu_unit.sv
branch_unit.sv
load_store_unit.sv
core_control.sv
cpu_core.sv
cpu_core_properties.sv
tb_cpu_core.sv
